// File: bench/mem_sys_stim.txt
# op addr be wdata expected_rdata expected_err
# op is R or W, all other columns hex
W 00000000 f 11223344 00000000 0
W 00000004 f aabbccdd 00000000 0
W 00000004 3 00005566 00000000 0
W 00000008 f 01020304 00000000 0
W 00000008 c 99880000 00000000 0
W 00000009 1 000000ee 00000000 0
R 00000000 f 00000000 11223344 0
R 00000004 f 00000000 aabb5566 0
R 00000008 f 00000000 998803ee 0
W 40000010 f deadbeef 00000000 0
W 40000014 f cafef00d 00000000 0
W 40000020 3 00001234 00000000 0
R 40000010 f 00000000 deadbeef 0
R 40000014 f 00000000 cafef00d 0
R 40000020 f 00000000 00001234 0
W 40000810 f 55555555 00000000 1
R 40000810 f 00000000 00000000 1
R 40000010 f 00000000 deadbeef 0
R 80000000 f 00000000 00000000 1
W 20000000 f 12345678 00000000 1
R 000003fc f 00000000 00000000 0

// File: mem_sys.f
+incdir+include
src/mem_sys_pkg.sv
src/addr_decode.sv
src/local_ram.sv
src/axi_lite_master.sv
src/resp_merge.sv
src/mem_sys.sv
bench/mem_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f mem_sys.f --top-module mem_sys_tb
out=$(./obj_dir/Vmem_sys_tb)
echo "$out"
echo "$out" | grep -qx "NO ERRORS"

// File: bench/mem_sys_tb.sv
`timescale 1ns/10ps
`include "mem_sys_config.svh"

module mem_sys_tb;

    localparam int TIMEOUT = 50;

    logic Clk = 1'b0;
    logic rst_n_i;
    logic req_i;
    logic we_i;
    logic [31:0] addr_i;
    logic [31:0] wdata_i;
    logic [3:0] be_i;
    logic busy_o;
    logic rsp_valid_o;
    logic rsp_err_o;
    logic [31:0] rsp_rdata_o;
    logic [31:0] awaddr;
    logic [31:0] wdata;
    logic [31:0] araddr;
    logic [31:0] rdata;
    logic [3:0] wstrb;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    mem_sys_pkg::axi_resp_t bresp;
    mem_sys_pkg::axi_resp_t rresp;

    logic [31:0] periph_mem [256];
    logic [31:0] rng = 32'h2e50522b;
    logic [31:0] cur_addr;
    logic [31:0] cur_wdata;
    logic [3:0] cur_be;
    int errors = 0;
    int accepted = 0;
    int responses = 0;
    bit aborted = 0;

    mem_sys mem_sys_i (
        .Clk             (Clk),
        .rst_n_i         (rst_n_i),
        .req_i           (req_i),
        .we_i            (we_i),
        .addr_i          (addr_i),
        .be_i            (be_i),
        .wdata_i         (wdata_i),
        .busy_o          (busy_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .rsp_err_o       (rsp_err_o),
        .m_axi_awaddr_o  (awaddr),
        .m_axi_awvalid_o (awvalid),
        .m_axi_awready_i (awready),
        .m_axi_wdata_o   (wdata),
        .m_axi_wstrb_o   (wstrb),
        .m_axi_wvalid_o  (wvalid),
        .m_axi_wready_i  (wready),
        .m_axi_bresp_i   (bresp),
        .m_axi_bvalid_i  (bvalid),
        .m_axi_bready_o  (bready),
        .m_axi_araddr_o  (araddr),
        .m_axi_arvalid_o (arvalid),
        .m_axi_arready_i (arready),
        .m_axi_rdata_i   (rdata),
        .m_axi_rresp_i   (rresp),
        .m_axi_rvalid_i  (rvalid),
        .m_axi_rready_o  (rready)
    );

    always #50 Clk = ~Clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Random wait of 0 to 3 cycles before a ready or valid
    task automatic random_delay();
        int n;
        rng = xorshift(rng);
        n = rng[1:0];
        for (int i = 0; i < n; i++)
            @(negedge Clk);
    endtask

    ////////////////////////////////////////////////////////////
    // AXI4-Lite slave model, SLVERR on address bit 11
    ////////////////////////////////////////////////////////////
    initial begin
        int cycles;
        awready = 0;
        wready = 0;
        bvalid = 0;
        arready = 0;
        rvalid = 0;
        bresp = mem_sys_pkg::OKAY;
        rresp = mem_sys_pkg::OKAY;
        rdata = '0;
        for (int i = 0; i < 256; i++)
            periph_mem[i] = '0;
        forever begin
            @(negedge Clk);
            if (awvalid && wvalid) begin
                random_delay();
                check_value("m_axi_awaddr_o", cur_addr, awaddr);
                awready = 1;
                @(negedge Clk);
                awready = 0;
                random_delay();
                check_value("m_axi_wdata_o", cur_wdata, wdata);
                check_value("m_axi_wstrb_o", {28'h0, cur_be}, {28'h0, wstrb});
                wready = 1;
                @(negedge Clk);
                wready = 0;
                for (int b = 0; b < 4; b++)
                    if (wstrb[b] && !awaddr[11])
                        periph_mem[awaddr[9:2]][8*b +: 8] = wdata[8*b +: 8];
                random_delay();
                bresp = awaddr[11] ? mem_sys_pkg::SLVERR : mem_sys_pkg::OKAY;
                bvalid = 1;
                // Response held until the master takes it
                cycles = 0;
                while (!bready && cycles < TIMEOUT) begin
                    @(negedge Clk);
                    cycles++;
                end
                if (!bready) begin
                    errors++;
                    $display("Timeout: bready never rose for a write response");
                end
                @(negedge Clk);
                bvalid = 0;
            end else if (arvalid) begin
                random_delay();
                check_value("m_axi_araddr_o", cur_addr, araddr);
                arready = 1;
                @(negedge Clk);
                arready = 0;
                random_delay();
                rresp = araddr[11] ? mem_sys_pkg::SLVERR : mem_sys_pkg::OKAY;
                rdata = araddr[11] ? 32'hbad0_bad0 : periph_mem[araddr[9:2]];
                rvalid = 1;
                cycles = 0;
                while (!rready && cycles < TIMEOUT) begin
                    @(negedge Clk);
                    cycles++;
                end
                if (!rready) begin
                    errors++;
                    $display("Timeout: rready never rose for a read response");
                end
                @(negedge Clk);
                rvalid = 0;
            end
        end
    end

    always @(negedge Clk)
        if (rst_n_i && rsp_valid_o)
            responses++;

    // One access, with a spurious req_i pulse while busy
    task automatic run_access(input logic w, input logic [31:0] a, input logic [3:0] be,
                              input logic [31:0] d, input logic [31:0] exp_d, input logic exp_e);
        int cycles;
        bit done;
        bit fixed_lat;
        cycles = 0;
        done = 0;
        fixed_lat = (a < 32'h400) || (a[31:28] != 4'h4);
        cur_addr = a;
        cur_wdata = d;
        cur_be = be;
        req_i = 1;
        we_i = w;
        addr_i = a;
        be_i = be;
        wdata_i = d;
        accepted++;
        while (!done && cycles < TIMEOUT) begin
            @(negedge Clk);
            cycles++;
            if (cycles == 1)
                wdata_i = ~d;
            if (cycles == 2)
                req_i = 0;
            if (a >= 32'h400 && a[31:28] != 4'h4)
                assert (!awvalid && !wvalid && !arvalid) else begin
                    errors++;
                    $display("AXI valid raised for unmapped address %h at %0t", a, $time);
                end
            if (rsp_valid_o) begin
                done = 1;
                check_value("rsp_rdata_o", exp_d, rsp_rdata_o);
                check_value("rsp_err_o", {31'h0, exp_e}, {31'h0, rsp_err_o});
                if (fixed_lat)
                    check_value("response latency", 32'd2, cycles);
            end
        end
        req_i = 0;
        if (!done) begin
            errors++;
            aborted = 1;
            $display("Timeout: no response for access to %h", a);
            return;
        end
        cycles = 0;
        while (busy_o && cycles < TIMEOUT) begin
            @(negedge Clk);
            cycles++;
        end
        if (busy_o) begin
            errors++;
            aborted = 1;
            $display("Timeout: busy_o stuck high after access to %h", a);
        end
    endtask

    initial begin
        int fd;
        int n;
        string line;
        logic [7:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] exp_d;
        logic [3:0] be;
        logic exp_e;
        rst_n_i = 0;
        req_i = 0;
        we_i = 0;
        addr_i = '0;
        be_i = '0;
        wdata_i = '0;
        cur_addr = '0;
        cur_wdata = '0;
        cur_be = '0;
        repeat (4) @(negedge Clk);
        rst_n_i = 1;
        @(negedge Clk);
        assert (!busy_o && !rsp_valid_o && !awvalid && !wvalid && !arvalid &&
                !bready && !rready) else begin
            errors++;
            $display("Outputs not idle after reset");
        end
        // Clear the whole RAM before the first read
        for (int i = 0; i < `MEM_SYS_RAM_WORDS && !aborted; i++)
            run_access(1'b1, i * 4, 4'hf, 32'h0, 32'h0, 1'b0);
        fd = $fopen("bench/mem_sys_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stimulus file");
        end else begin
            while (!aborted && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%c %h %h %h %h %h", op, a, be, d, exp_d, exp_e);
                if (n == 6)
                    run_access(op == "W", a, be, d, exp_d, exp_e);
            end
            $fclose(fd);
        end
        repeat (3) @(negedge Clk);
        check_value("response count", accepted, responses);
        $display("%0d errors, %0d accesses, %0d responses", errors, accepted, responses);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: src/mem_sys.sv
`timescale 1ns/10ps
`include "mem_sys_config.svh"

module mem_sys (
    input  logic                        Clk,
    input  logic                        rst_n_i,
    // Processor data port
    input  logic                        req_i,
    input  logic                        we_i,
    input  logic [`MEM_SYS_ADDR_W-1:0]  addr_i,
    input  logic [`MEM_SYS_BE_W-1:0]    be_i,
    input  logic [`MEM_SYS_DATA_W-1:0]  wdata_i,
    output logic                        busy_o,
    output logic                        rsp_valid_o,
    output logic [`MEM_SYS_DATA_W-1:0]  rsp_rdata_o,
    output logic                        rsp_err_o,
    // Peripheral AXI4-Lite master
    output logic [`MEM_SYS_ADDR_W-1:0]  m_axi_awaddr_o,
    output logic                        m_axi_awvalid_o,
    input  logic                        m_axi_awready_i,
    output logic [`MEM_SYS_DATA_W-1:0]  m_axi_wdata_o,
    output logic [`MEM_SYS_BE_W-1:0]    m_axi_wstrb_o,
    output logic                        m_axi_wvalid_o,
    input  logic                        m_axi_wready_i,
    input  mem_sys_pkg::axi_resp_t      m_axi_bresp_i,
    input  logic                        m_axi_bvalid_i,
    output logic                        m_axi_bready_o,
    output logic [`MEM_SYS_ADDR_W-1:0]  m_axi_araddr_o,
    output logic                        m_axi_arvalid_o,
    input  logic                        m_axi_arready_i,
    input  logic [`MEM_SYS_DATA_W-1:0]  m_axi_rdata_i,
    input  mem_sys_pkg::axi_resp_t      m_axi_rresp_i,
    input  logic                        m_axi_rvalid_i,
    output logic                        m_axi_rready_o
);

    mem_sys_pkg::mem_target_t   tgt;
    logic                       ram_en;
    logic                       ram_we;
    logic                       axi_start_rd;
    logic                       axi_start_wr;
    logic [`MEM_SYS_ADDR_W-1:0] acc_addr;
    logic [`MEM_SYS_BE_W-1:0]   acc_be;
    logic [`MEM_SYS_DATA_W-1:0] acc_wdata;
    logic [`MEM_SYS_DATA_W-1:0] ram_rdata;
    logic                       axi_done;
    logic [`MEM_SYS_DATA_W-1:0] axi_rdata;
    logic                       axi_err;
    logic                       rsp_done;

    addr_decode addr_decode_i (
        .Clk            (Clk),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .we_i           (we_i),
        .addr_i         (addr_i),
        .be_i           (be_i),
        .wdata_i        (wdata_i),
        .rsp_done_i     (rsp_done),
        .busy_o         (busy_o),
        .tgt_o          (tgt),
        .ram_en_o       (ram_en),
        .ram_we_o       (ram_we),
        .axi_start_rd_o (axi_start_rd),
        .axi_start_wr_o (axi_start_wr),
        .acc_addr_o     (acc_addr),
        .acc_be_o       (acc_be),
        .acc_wdata_o    (acc_wdata)
    );

    local_ram local_ram_i (
        .Clk     (Clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (acc_addr),
        .be_i    (acc_be),
        .wdata_i (acc_wdata),
        .rdata_o (ram_rdata)
    );

    axi_lite_master axi_lite_master_i (
        .Clk             (Clk),
        .rst_n_i         (rst_n_i),
        .start_rd_i      (axi_start_rd),
        .start_wr_i      (axi_start_wr),
        .addr_i          (acc_addr),
        .be_i            (acc_be),
        .wdata_i         (acc_wdata),
        .done_o          (axi_done),
        .rdata_o         (axi_rdata),
        .err_o           (axi_err),
        .m_axi_awaddr_o  (m_axi_awaddr_o),
        .m_axi_awvalid_o (m_axi_awvalid_o),
        .m_axi_awready_i (m_axi_awready_i),
        .m_axi_wdata_o   (m_axi_wdata_o),
        .m_axi_wstrb_o   (m_axi_wstrb_o),
        .m_axi_wvalid_o  (m_axi_wvalid_o),
        .m_axi_wready_i  (m_axi_wready_i),
        .m_axi_bresp_i   (m_axi_bresp_i),
        .m_axi_bvalid_i  (m_axi_bvalid_i),
        .m_axi_bready_o  (m_axi_bready_o),
        .m_axi_araddr_o  (m_axi_araddr_o),
        .m_axi_arvalid_o (m_axi_arvalid_o),
        .m_axi_arready_i (m_axi_arready_i),
        .m_axi_rdata_i   (m_axi_rdata_i),
        .m_axi_rresp_i   (m_axi_rresp_i),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .m_axi_rready_o  (m_axi_rready_o)
    );

    resp_merge resp_merge_i (
        .Clk         (Clk),
        .rst_n_i     (rst_n_i),
        .tgt_i       (tgt),
        .ram_en_i    (ram_en),
        .ram_we_i    (ram_we),
        .ram_rdata_i (ram_rdata),
        .axi_done_i  (axi_done),
        .axi_rdata_i (axi_rdata),
        .axi_err_i   (axi_err),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .rsp_done_o  (rsp_done)
    );

endmodule

// File: src/resp_merge.sv
`timescale 1ns/10ps
`include "mem_sys_config.svh"

module resp_merge (
    input  logic                        Clk,
    input  logic                        rst_n_i,
    input  mem_sys_pkg::mem_target_t    tgt_i,
    input  logic                        ram_en_i,
    input  logic                        ram_we_i,
    input  logic [`MEM_SYS_DATA_W-1:0]  ram_rdata_i,
    input  logic                        axi_done_i,
    input  logic [`MEM_SYS_DATA_W-1:0]  axi_rdata_i,
    input  logic                        axi_err_i,
    output logic                        rsp_valid_o,
    output logic [`MEM_SYS_DATA_W-1:0]  rsp_rdata_o,
    output logic                        rsp_err_o,
    output logic                        rsp_done_o
);

    logic ram_pend_q;
    logic ram_wr_q;
    logic none_pend_q;

    // RAM data is out one cycle after ram_en
    always_ff @(posedge Clk) begin
        if (!rst_n_i) begin
            ram_pend_q  <= 1'b0;
            ram_wr_q    <= 1'b0;
            none_pend_q <= 1'b0;
        end else begin
            ram_pend_q  <= ram_en_i;
            ram_wr_q    <= ram_we_i;
            // Unmapped access answers on the cycle after it shows up
            none_pend_q <= (tgt_i == mem_sys_pkg::TGT_NONE) && !none_pend_q;
        end
    end

    always_comb begin
        rsp_valid_o = ram_pend_q || none_pend_q || axi_done_i;
        rsp_err_o   = none_pend_q || (axi_done_i && axi_err_i);
        rsp_rdata_o = '0;
        if (ram_pend_q && !ram_wr_q)
            rsp_rdata_o = ram_rdata_i;
        else if (axi_done_i && !axi_err_i)
            rsp_rdata_o = axi_rdata_i;
    end

    assign rsp_done_o = rsp_valid_o;

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    a_one_source: assert property (
        @(posedge Clk) disable iff (!rst_n_i)
        $onehot0({ram_pend_q, none_pend_q, axi_done_i})
    );

    // AXI completion only for a peripheral access
    a_axi_tgt: assert property (
        @(posedge Clk) disable iff (!rst_n_i)
        axi_done_i |-> tgt_i == mem_sys_pkg::TGT_PERIPH
    );

endmodule

// File: src/axi_lite_master.sv
`timescale 1ns/10ps
`include "mem_sys_config.svh"

module axi_lite_master (
    input  logic                        Clk,
    input  logic                        rst_n_i,
    input  logic                        start_rd_i,
    input  logic                        start_wr_i,
    input  logic [`MEM_SYS_ADDR_W-1:0]  addr_i,
    input  logic [`MEM_SYS_BE_W-1:0]    be_i,
    input  logic [`MEM_SYS_DATA_W-1:0]  wdata_i,
    output logic                        done_o,
    output logic [`MEM_SYS_DATA_W-1:0]  rdata_o,
    output logic                        err_o,
    // Write address / data / response
    output logic [`MEM_SYS_ADDR_W-1:0]  m_axi_awaddr_o,
    output logic                        m_axi_awvalid_o,
    input  logic                        m_axi_awready_i,
    output logic [`MEM_SYS_DATA_W-1:0]  m_axi_wdata_o,
    output logic [`MEM_SYS_BE_W-1:0]    m_axi_wstrb_o,
    output logic                        m_axi_wvalid_o,
    input  logic                        m_axi_wready_i,
    input  mem_sys_pkg::axi_resp_t      m_axi_bresp_i,
    input  logic                        m_axi_bvalid_i,
    output logic                        m_axi_bready_o,
    // Read address / data
    output logic [`MEM_SYS_ADDR_W-1:0]  m_axi_araddr_o,
    output logic                        m_axi_arvalid_o,
    input  logic                        m_axi_arready_i,
    input  logic [`MEM_SYS_DATA_W-1:0]  m_axi_rdata_i,
    input  mem_sys_pkg::axi_resp_t      m_axi_rresp_i,
    input  logic                        m_axi_rvalid_i,
    output logic                        m_axi_rready_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } state_t;

    state_t                     state_q;
    logic [`MEM_SYS_ADDR_W-1:0] addr_q;
    logic                       start;
    logic                       b_hs;
    logic                       r_hs;

    assign start = (start_rd_i || start_wr_i) && (state_q == ST_IDLE);
    assign b_hs  = m_axi_bvalid_i && m_axi_bready_o;
    assign r_hs  = m_axi_rvalid_i && m_axi_rready_o;

    // One address register serves both channels
    assign m_axi_awaddr_o = addr_q;
    assign m_axi_araddr_o = addr_q;

    ////////////////////////////////////////////////////////////
    // Channel FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rst_n_i) begin
            state_q         <= ST_IDLE;
            m_axi_awvalid_o <= 1'b0;
            m_axi_wvalid_o  <= 1'b0;
            m_axi_bready_o  <= 1'b0;
            m_axi_arvalid_o <= 1'b0;
            m_axi_rready_o  <= 1'b0;
            done_o          <= 1'b0;
            err_o           <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_wr_i) begin
                        state_q         <= ST_WRITE;
                        m_axi_awvalid_o <= 1'b1;
                        m_axi_wvalid_o  <= 1'b1;
                        m_axi_bready_o  <= 1'b1;
                    end else if (start_rd_i) begin
                        state_q         <= ST_READ;
                        m_axi_arvalid_o <= 1'b1;
                        m_axi_rready_o  <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    // AW and W complete on their own
                    if (m_axi_awready_i)
                        m_axi_awvalid_o <= 1'b0;
                    if (m_axi_wready_i)
                        m_axi_wvalid_o <= 1'b0;
                    if (b_hs) begin
                        m_axi_bready_o <= 1'b0;
                        done_o         <= 1'b1;
                        err_o          <= (m_axi_bresp_i != mem_sys_pkg::OKAY);
                        state_q        <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (m_axi_arready_i)
                        m_axi_arvalid_o <= 1'b0;
                    if (r_hs) begin
                        m_axi_rready_o <= 1'b0;
                        done_o         <= 1'b1;
                        err_o          <= (m_axi_rresp_i != mem_sys_pkg::OKAY);
                        state_q        <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Payload, held until the access is done
    always_ff @(posedge Clk) begin
        if (start) begin
            addr_q        <= addr_i;
            m_axi_wdata_o <= wdata_i;
            m_axi_wstrb_o <= be_i;
            // Writes return zero data
            rdata_o       <= '0;
        end else if (r_hs) begin
            rdata_o <= m_axi_rdata_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Valid held with stable payload until ready
    ////////////////////////////////////////////////////////////
    a_aw_stable: assert property (
        @(posedge Clk) disable iff (!rst_n_i)
        m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o && $stable(m_axi_awaddr_o)
    );

    a_w_stable: assert property (
        @(posedge Clk) disable iff (!rst_n_i)
        m_axi_wvalid_o && !m_axi_wready_i |=>
            m_axi_wvalid_o && $stable(m_axi_wdata_o) && $stable(m_axi_wstrb_o)
    );

    a_ar_stable: assert property (
        @(posedge Clk) disable iff (!rst_n_i)
        m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o)
    );

endmodule

// File: src/local_ram.sv
`timescale 1ns/10ps
`include "mem_sys_config.svh"

module local_ram (
    input  logic                        Clk,
    input  logic                        en_i,
    input  logic                        we_i,
    input  logic [`MEM_SYS_ADDR_W-1:0]  addr_i,
    input  logic [`MEM_SYS_BE_W-1:0]    be_i,
    input  logic [`MEM_SYS_DATA_W-1:0]  wdata_i,
    output logic [`MEM_SYS_DATA_W-1:0]  rdata_o
);

    localparam int IDX_W = $clog2(`MEM_SYS_RAM_WORDS);

    logic [`MEM_SYS_DATA_W-1:0] mem [`MEM_SYS_RAM_WORDS];
    logic [IDX_W-1:0]           idx;

    // Word index, byte offset dropped
    assign idx = addr_i[IDX_W+1:2];

    always_ff @(posedge Clk) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < `MEM_SYS_BE_W; b++) begin
                    if (be_i[b])
                        mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
            // Old word on a write to the same address
            rdata_o <= mem[idx];
        end
    end

endmodule

// File: src/addr_decode.sv
`timescale 1ns/10ps
`include "mem_sys_config.svh"

module addr_decode (
    input  logic                        Clk,
    input  logic                        rst_n_i,
    input  logic                        req_i,
    input  logic                        we_i,
    input  logic [`MEM_SYS_ADDR_W-1:0]  addr_i,
    input  logic [`MEM_SYS_BE_W-1:0]    be_i,
    input  logic [`MEM_SYS_DATA_W-1:0]  wdata_i,
    input  logic                        rsp_done_i,
    output logic                        busy_o,
    output mem_sys_pkg::mem_target_t    tgt_o,
    output logic                        ram_en_o,
    output logic                        ram_we_o,
    output logic                        axi_start_rd_o,
    output logic                        axi_start_wr_o,
    output logic [`MEM_SYS_ADDR_W-1:0]  acc_addr_o,
    output logic [`MEM_SYS_BE_W-1:0]    acc_be_o,
    output logic [`MEM_SYS_DATA_W-1:0]  acc_wdata_o
);

    logic accept;
    logic in_ram;
    logic in_periph;

    assign accept    = req_i && !busy_o;
    assign in_ram    = (addr_i - `MEM_SYS_RAM_BASE) < (`MEM_SYS_RAM_WORDS * 4);
    assign in_periph = (addr_i & `MEM_SYS_PERIPH_MASK) ==
                       (`MEM_SYS_PERIPH_BASE & `MEM_SYS_PERIPH_MASK);

    ////////////////////////////////////////////////////////////
    // Control: busy, target and one-cycle strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rst_n_i) begin
            busy_o         <= 1'b0;
            tgt_o          <= mem_sys_pkg::TGT_RAM;
            ram_en_o       <= 1'b0;
            ram_we_o       <= 1'b0;
            axi_start_rd_o <= 1'b0;
            axi_start_wr_o <= 1'b0;
        end else begin
            ram_en_o       <= accept && in_ram;
            ram_we_o       <= accept && in_ram && we_i;
            axi_start_rd_o <= accept && !in_ram && in_periph && !we_i;
            axi_start_wr_o <= accept && !in_ram && in_periph && we_i;
            if (accept) begin
                busy_o <= 1'b1;
                if (in_ram)
                    tgt_o <= mem_sys_pkg::TGT_RAM;
                else if (in_periph)
                    tgt_o <= mem_sys_pkg::TGT_PERIPH;
                else
                    tgt_o <= mem_sys_pkg::TGT_NONE;
            end else if (rsp_done_i) begin
                busy_o <= 1'b0;
                // Idle value, so each unmapped access shows as a new TGT_NONE
                tgt_o  <= mem_sys_pkg::TGT_RAM;
            end
        end
    end

    // Held access, for both RAM and AXI
    always_ff @(posedge Clk) begin
        if (accept) begin
            acc_addr_o  <= addr_i;
            acc_be_o    <= be_i;
            acc_wdata_o <= wdata_i;
        end
    end

    // Completion comes back only for an access in flight
    a_done_when_busy: assert property (
        @(posedge Clk) disable iff (!rst_n_i) rsp_done_i |-> busy_o
    );

endmodule

// File: src/mem_sys_pkg.sv
package mem_sys_pkg;

    // Where a data access is sent
    typedef enum logic [1:0] {
        TGT_RAM    = 2'd0,
        TGT_PERIPH = 2'd1,
        TGT_NONE   = 2'd2
    } mem_target_t;

    // AXI BRESP / RRESP encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

endpackage

// File: include/mem_sys_config.svh
`ifndef MEM_SYS_CONFIG_SVH
`define MEM_SYS_CONFIG_SVH

// Data port widths
`define MEM_SYS_ADDR_W 32
`define MEM_SYS_DATA_W 32
`define MEM_SYS_BE_W 4

// On-chip RAM window, 1 KiB
`define MEM_SYS_RAM_BASE 32'h0000_0000
`define MEM_SYS_RAM_WORDS 256

// Peripheral window, matched on the top nibble
`define MEM_SYS_PERIPH_BASE 32'h4000_0000
`define MEM_SYS_PERIPH_MASK 32'hF000_0000

`endif
